// ==== exec_stimulus.txt ====
# kind op rob src_a src_b src_c dest flag arch imm want; preload lines are: p addr data
# want: a result, m {addr,data}, t {fail,target}; all fields hex
p 0d00 a7
a 7 01 00 00 00 01 1f 1 9 09
m a 02 00 00 01 00 00 0 1 000109
a 7 03 00 00 00 02 1f 2 c 0c
m a 04 00 00 02 00 00 0 2 00020c
a 0 05 01 02 00 03 1f 3 0 15
m a 06 00 00 03 00 00 0 3 000315
a 1 07 01 02 00 04 14 4 0 fd
m a 08 00 00 04 00 00 0 4 0004fd
a 2 09 03 04 00 05 1f 5 0 15
m a 0a 00 00 05 00 00 0 5 000515
a 3 0b 01 02 00 06 1f 6 0 0d
m a 0c 00 00 06 00 00 0 6 00060d
a 4 0d 01 01 00 07 16 7 0 00
m a 0e 00 00 07 00 00 0 7 000700
a 5 0f 04 00 00 08 1f 8 0 fa
m a 10 00 00 08 00 00 0 8 0008fa
a 6 11 03 00 00 09 1f 9 0 0a
m a 12 00 00 09 00 00 0 9 00090a
a 8 13 04 00 00 0a 15 a f 0c
m a 14 00 00 0a 00 00 0 a 000a0c
m a 15 01 04 03 00 00 0 7 0a0415
m 9 16 02 08 00 0c 00 0 6 0d00a7
m a 17 00 00 0c 00 00 0 f 000fa7
t c 18 01 02 16 00 00 0 3 0090f
t d 19 04 08 16 00 00 0 9 1fe03
t e 1a 00 03 16 00 00 0 0 10015
t e 1b 06 0a 15 00 00 0 f 00d1b
t b 1c 09 05 00 00 00 0 1 00a16

// ==== compile.f ====
exec_pkg.sv
wb_if.sv
phys_reg_file.sv
arith_pipeline.sv
mem_pipeline.sv
term_pipeline.sv
middle_end.sv
middle_end_asserts.sv
tb_middle_end.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_middle_end
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+10

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(RUN_ARGS)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_middle_end.sv ====
`timescale 1ns/1ps

module tb_middle_end import exec_pkg::*; ();

    localparam int max_records = 64;
    localparam int hold_cycles = 4;  // ROB back-pressure on every jump

    logic        clk;
    logic        rst_n;
    renamed_op_t arith_instr;
    logic        arith_valid;
    renamed_op_t mem_instr;
    logic        mem_valid;
    logic        mem_ready;
    renamed_op_t term_instr;
    logic        term_valid;
    logic        term_ready;
    addr_t       mem_addr;
    logic        mem_store;
    word_t       mem_dout;
    word_t       mem_din;
    logic        complete_arith_valid;
    rob_idx_t    arith_rob_entry;
    logic        complete_mem_valid;
    rob_idx_t    mem_rob_entry;
    logic        complete_term_valid;
    logic        complete_term_ready;
    logic        complete_term_failed;
    addr_t       term_address;
    rob_idx_t    term_rob_entry;

    word_t       mem_model [65536];
    word_t       read_word;
    byte         rec_kind [max_records];
    renamed_op_t rec_op   [max_records];
    logic [23:0] rec_want [max_records];
    int          n_records;
    int          n_lines;
    logic        loaded;

    middle_end dut (.*);

    bind middle_end middle_end_asserts u_asserts (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // synchronous memory returns data one cycle after the address
    always @(negedge clk) begin
        if (mem_store) begin
            mem_model[mem_addr] = mem_dout;
        end
        read_word = mem_model[mem_addr];
        @(posedge clk);
        #1;
        mem_din = read_word;
    end

    initial begin
        wait (loaded === 1'b1);
        repeat (n_lines * 40 + 100) @(posedge clk);
        fail_run("watchdog expired, a completion never arrived");
    end

    always @(negedge clk) begin
        if (dut.u_asserts.fail_count != 0) begin
            fail_run("a protocol assertion failed");
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t want);
        if (got !== want) begin
            fail_run($sformatf("error: %s is %h, expected %h", name, got, want));
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t want);
        if (got !== want) begin
            fail_run($sformatf("error: %s is %h, expected %h", name, got, want));
        end
    endtask

    task automatic check_rob(input string name, input rob_idx_t got, input rob_idx_t want);
        if (got !== want) begin
            fail_run($sformatf("error: %s is %h, expected %h", name, got, want));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            fail_run($sformatf("error: %s is %h, expected %h", name, got, want));
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        renamed_op_t op;
        logic [31:0] f_op, f_rob, f_a, f_b, f_c, f_dest, f_flag, f_arch, f_imm, f_want;
        fd = $fopen("exec_stimulus.txt", "r");
        if (fd == 0) begin
            fail_run("could not open exec_stimulus.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n_lines++;
            if (line.getc(0) == "p") begin  // memory preload
                n = $sscanf(line.substr(2, line.len() - 1), "%h %h", f_a, f_want);
                mem_model[f_a[15:0]] = f_want[7:0];
                continue;
            end
            n = $sscanf(line.substr(2, line.len() - 1), "%h %h %h %h %h %h %h %h %h %h",
                        f_op, f_rob, f_a, f_b, f_c, f_dest, f_flag, f_arch, f_imm, f_want);
            if (n != 10 || n_records >= max_records) begin
                fail_run("stimulus line is malformed or there are too many lines");
            end
            op           = '0;
            op.opcode    = op_e'(f_op[3:0]);
            op.rob_entry = f_rob[4:0];
            op.src_a     = f_a[4:0];
            op.src_b     = f_b[4:0];
            op.src_c     = f_c[4:0];
            op.phys_dest = f_dest[4:0];
            op.phys_flag = f_flag[4:0];
            op.arch_dest = f_arch[3:0];
            op.imm       = f_imm[3:0];
            rec_kind[n_records] = line.getc(0);
            rec_op[n_records]   = op;
            rec_want[n_records] = f_want[23:0];
            n_records++;
        end
        $fclose(fd);
    endtask

    // always accepted with a fixed one-cycle latency
    task automatic run_arith(input renamed_op_t op);
        @(posedge clk);
        #1;
        arith_instr = op;
        arith_valid = 1'b1;
        @(posedge clk);
        #1;
        arith_valid = 1'b0;
        @(negedge clk);
        check_bit("complete_arith_valid", complete_arith_valid, 1'b1);
        check_rob("arith_rob_entry", arith_rob_entry, op.rob_entry);
        @(negedge clk);
        check_bit("complete_arith_valid", complete_arith_valid, 1'b0);
    endtask

    task automatic run_mem(input renamed_op_t op, input logic [23:0] want);
        int   cycles;
        logic is_store;
        is_store = (op.opcode == op_st);
        cycles   = 0;
        while (!mem_ready) @(negedge clk);
        @(posedge clk);
        #1;
        mem_instr = op;
        mem_valid = 1'b1;
        @(posedge clk);
        #1;
        mem_valid = 1'b0;
        do begin
            @(negedge clk);
            cycles++;
            check_bit("mem_ready", mem_ready, 1'b0);  // busy until completion
        end while (!complete_mem_valid);
        if (cycles != (is_store ? 1 : 2)) begin
            fail_run("memory completion arrived in the wrong cycle");
        end
        check_rob("mem_rob_entry", mem_rob_entry, op.rob_entry);
        check_addr("mem_addr", mem_addr, want[23:8]);
        check_bit("mem_store", mem_store, is_store);
        if (is_store) begin
            check_word("mem_dout", mem_dout, want[7:0]);
        end else begin
            check_word("mem_din", mem_din, want[7:0]);
        end
    endtask

    task automatic run_term(input renamed_op_t op, input logic [16:0] want);
        while (!term_ready) @(negedge clk);
        @(posedge clk);
        #1;
        term_instr = op;
        term_valid = 1'b1;
        @(posedge clk);
        #1;
        term_valid = 0;
        @(negedge clk);
        // result is up in the cycle after acceptance
        repeat (hold_cycles) begin
            check_bit("complete_term_valid", complete_term_valid, 1'b1);
            check_bit("term_ready", term_ready, 1'b0);
            check_addr("term_address", term_address, want[15:0]);
            check_bit("complete_term_failed", complete_term_failed, want[16]);
            check_rob("term_rob_entry", term_rob_entry, op.rob_entry);
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        complete_term_ready = 1'b1;
        @(posedge clk);
        #1;
        complete_term_ready = 1'b0;
        @(negedge clk);
        check_bit("complete_term_valid", complete_term_valid, 1'b0);
        check_bit("term_ready", term_ready, 1'b1);
    endtask

    initial begin
        rst_n               = 1'b0;
        arith_instr         = '0;
        arith_valid         = 1'b0;
        mem_instr           = '0;
        mem_valid           = 1'b0;
        term_instr          = '0;
        term_valid          = 1'b0;
        mem_din             = '0;
        complete_term_ready = 1'b0;
        n_records           = 0;
        n_lines             = 0;
        loaded              = 1'b0;
        for (int i = 0; i < 65536; i++) begin
            mem_model[i] = word_t'(i[15:8] ^ i[7:0] ^ 8'h5a);
        end
        load_stimulus();
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int i = 0; i < n_records; i++) begin
            case (rec_kind[i])
                "a":     run_arith(rec_op[i]);
                "m":     run_mem(rec_op[i], rec_want[i]);
                "t":     run_term(rec_op[i], rec_want[i][16:0]);
                default: fail_run("unknown queue letter in the stimulus file");
            endcase
        end
        repeat (2) @(negedge clk);
        if (dut.u_asserts.fail_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            fail_run("protocol assertions failed during the run");
        end
    end

endmodule

// ==== middle_end_asserts.sv ====
`timescale 1ns/1ps

module middle_end_asserts import exec_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  mem_valid,
    input logic  mem_ready,
    input logic  mem_store,
    input logic  complete_mem_valid,
    input logic  complete_arith_valid,
    input logic  complete_term_valid,
    input logic  complete_term_ready,
    input addr_t term_address
);

    int unsigned fail_count = 0;  // read by the testbench

    store_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mem_store |=> !mem_store)
        else begin
            fail_count++;
            $error("mem_store high in two consecutive cycles");
        end

    // jump result held until the ROB takes it
    term_hold: assert property (@(posedge clk) disable iff (!rst_n)
        complete_term_valid && !complete_term_ready
            |=> complete_term_valid && $stable(term_address))
        else begin
            fail_count++;
            $error("terminate result changed before complete_term_ready");
        end

    mem_accept_busy: assert property (@(posedge clk) disable iff (!rst_n)
        mem_valid && mem_ready |=> !mem_ready)
        else begin
            fail_count++;
            $error("mem_ready high right after an accepted memory op");
        end

    mem_done_busy: assert property (@(posedge clk) disable iff (!rst_n)
        complete_mem_valid |-> !mem_ready)
        else begin
            fail_count++;
            $error("mem_ready high in the memory completion cycle");
        end

    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> !complete_arith_valid && !complete_mem_valid && !complete_term_valid)
        else begin
            fail_count++;
            $error("a completion was high during reset");
        end

endmodule

// ==== middle_end.sv ====
`timescale 1ns/1ps

module middle_end import exec_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  renamed_op_t arith_instr,
    input  logic        arith_valid,
    input  renamed_op_t mem_instr,
    input  logic        mem_valid,
    output logic        mem_ready,
    input  renamed_op_t term_instr,
    input  logic        term_valid,
    output logic        term_ready,
    output addr_t       mem_addr,
    output logic        mem_store,
    output word_t       mem_dout,
    input  word_t       mem_din,
    output logic        complete_arith_valid,
    output rob_idx_t    arith_rob_entry,
    output logic        complete_mem_valid,
    output rob_idx_t    mem_rob_entry,
    output logic        complete_term_valid,
    input  logic        complete_term_ready,
    output logic        complete_term_failed,
    output addr_t       term_address,
    output rob_idx_t    term_rob_entry
);

    localparam int rf_reads  = 8;
    localparam int rf_writes = 3;

    wb_if arith_res_wb ();
    wb_if arith_flag_wb ();
    wb_if mem_wb ();

    phys_reg_t            rd_addrs [rf_reads];
    word_t                rd_vals  [rf_reads];
    logic [rf_writes-1:0] wr_en;
    phys_reg_t            wr_addrs [rf_writes];
    word_t                wr_vals  [rf_writes];

    // read ports: arith a/b, mem hi/lo/data, term hi/lo/flags
    assign rd_addrs[0] = arith_instr.src_a;
    assign rd_addrs[1] = arith_instr.src_b;
    assign rd_addrs[2] = mem_instr.src_a;
    assign rd_addrs[3] = mem_instr.src_b;
    assign rd_addrs[4] = mem_instr.src_c;
    assign rd_addrs[5] = term_instr.src_a;
    assign rd_addrs[6] = term_instr.src_b;
    assign rd_addrs[7] = term_instr.src_c;

    // a store completes without writing a register
    assign wr_en       = {mem_wb.valid && !mem_store, arith_flag_wb.valid, arith_res_wb.valid};
    assign wr_addrs[0] = arith_res_wb.phys_dest;
    assign wr_addrs[1] = arith_flag_wb.phys_dest;
    assign wr_addrs[2] = mem_wb.phys_dest;
    assign wr_vals[0]  = arith_res_wb.value;
    assign wr_vals[1]  = arith_flag_wb.value;
    assign wr_vals[2]  = mem_wb.value;

    assign complete_arith_valid = arith_res_wb.valid;
    assign arith_rob_entry      = arith_res_wb.rob_entry;
    assign complete_mem_valid   = mem_wb.valid;
    assign mem_rob_entry        = mem_wb.rob_entry;

    phys_reg_file #(
        .num_read  (rf_reads),
        .num_write (rf_writes)
    ) u_reg_file (
        .clk         (clk),
        .rst_n       (rst_n),
        .read_addrs  (rd_addrs),
        .read_vals   (rd_vals),
        .write_en    (wr_en),
        .write_addrs (wr_addrs),
        .write_vals  (wr_vals)
    );

    arith_pipeline u_arith (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (arith_instr),
        .instr_valid (arith_valid),
        .op_a_val    (rd_vals[0]),
        .op_b_val    (rd_vals[1]),
        .res_wb      (arith_res_wb.source),
        .flag_wb     (arith_flag_wb.source)
    );

    mem_pipeline u_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (mem_instr),
        .instr_valid (mem_valid),
        .ready       (mem_ready),
        .base_hi     (rd_vals[2]),
        .base_lo     (rd_vals[3]),
        .store_val   (rd_vals[4]),
        .mem_addr    (mem_addr),
        .mem_store   (mem_store),
        .mem_dout    (mem_dout),
        .mem_din     (mem_din),
        .wb          (mem_wb.source)
    );

    term_pipeline u_term (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr        (term_instr),
        .instr_valid  (term_valid),
        .ready        (term_ready),
        .target_hi    (rd_vals[5]),
        .target_lo    (rd_vals[6]),
        .flags_val    (rd_vals[7]),
        .result_valid (complete_term_valid),
        .result_ready (complete_term_ready),
        .result_addr  (term_address),
        .failed       (complete_term_failed),
        .rob_entry    (term_rob_entry)
    );

endmodule

// ==== term_pipeline.sv ====
`timescale 1ns/1ps

module term_pipeline import exec_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  renamed_op_t instr,
    input  logic        instr_valid,
    output logic        ready,
    input  word_t       target_hi,
    input  word_t       target_lo,
    input  word_t       flags_val,
    output logic        result_valid,
    input  logic        result_ready,
    output addr_t       result_addr,
    output logic        failed,
    output rob_idx_t    rob_entry
);

    logic accept;
    logic cond_failed;

    assign ready  = !result_valid;
    assign accept = instr_valid && ready;

    always_comb begin
        case (instr.opcode)
            op_jz:   cond_failed = !flags_val[flag_z];
            op_jnz:  cond_failed = flags_val[flag_z];
            op_jc:   cond_failed = !flags_val[flag_c];
            default: cond_failed = 1'b0;  // jmp always taken
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else if (accept) begin
            result_valid <= 1'b1;
        end else if (result_ready) begin
            result_valid <= 1'b0;
        end
    end

    // held stable while waiting on the ROB
    always_ff @(posedge clk) begin
        if (accept) begin
            result_addr <= {target_hi, target_lo} + addr_t'(instr.imm);
            failed      <= cond_failed;
            rob_entry   <= instr.rob_entry;
        end
    end

endmodule

// ==== mem_pipeline.sv ====
`timescale 1ns/1ps

module mem_pipeline import exec_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  renamed_op_t instr,
    input  logic        instr_valid,
    output logic        ready,
    input  word_t       base_hi,
    input  word_t       base_lo,
    input  word_t       store_val,
    output addr_t       mem_addr,
    output logic        mem_store,
    output word_t       mem_dout,
    input  word_t       mem_din,
    wb_if.source        wb
);

    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_load_wait
    } state_e;

    state_e    state;
    logic      accept;

    addr_t     addr_q;
    word_t     data_q;
    rob_idx_t  rob_q;
    phys_reg_t dest_q;
    logic      store_q;

    assign ready  = (state == st_idle);  // one op in flight
    assign accept = instr_valid && ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        state <= st_access;
                    end
                end
                st_access:    state <= store_q ? st_idle : st_load_wait;
                st_load_wait: state <= st_idle;
                default:      state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= {base_hi, base_lo} + addr_t'(instr.imm);
            data_q  <= store_val;
            rob_q   <= instr.rob_entry;
            dest_q  <= instr.phys_dest;
            store_q <= (instr.opcode == op_st);
        end
    end

    // address held through the load wait
    assign mem_addr  = addr_q;
    assign mem_dout  = data_q;
    assign mem_store = (state == st_access) && store_q;

    // store completes in access, load one cycle later with memory data
    assign wb.valid     = mem_store || (state == st_load_wait);
    assign wb.rob_entry = rob_q;
    assign wb.phys_dest = dest_q;
    assign wb.value     = mem_din;

endmodule

// ==== arith_pipeline.sv ====
`timescale 1ns/1ps

module arith_pipeline import exec_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  renamed_op_t instr,
    input  logic        instr_valid,
    input  word_t       op_a_val,
    input  word_t       op_b_val,
    wb_if.source        res_wb,
    wb_if.source        flag_wb
);

    word_t     result;
    logic      carry;
    word_t     flags;
    word_t     imm_ext;

    logic      valid_q;
    rob_idx_t  rob_q;
    phys_reg_t dest_q;
    phys_reg_t flag_dest_q;
    word_t     result_q;
    word_t     flags_q;

    assign imm_ext = word_t'(instr.imm);

    always_comb begin
        carry = 1'b0;
        case (instr.opcode)
            op_add:  {carry, result} = {1'b0, op_a_val} + {1'b0, op_b_val};
            op_sub:  {carry, result} = {1'b0, op_a_val} - {1'b0, op_b_val};  // borrow
            op_and:  result = op_a_val & op_b_val;
            op_or:   result = op_a_val | op_b_val;
            op_xor:  result = op_a_val ^ op_b_val;
            op_shl:  {carry, result} = {op_a_val, 1'b0};
            op_shr:  {result, carry} = {1'b0, op_a_val};
            op_ldi:  result = imm_ext;
            op_addi: {carry, result} = {1'b0, op_a_val} + {1'b0, imm_ext};
            default: result = '0;
        endcase
    end

    always_comb begin
        flags         = '0;
        flags[flag_z] = (result == '0);
        flags[flag_c] = carry;
        flags[flag_n] = result[data_w-1];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        rob_q       <= instr.rob_entry;
        dest_q      <= instr.phys_dest;
        flag_dest_q <= instr.phys_flag;
        result_q    <= result;
        flags_q     <= flags;
    end

    assign res_wb.valid      = valid_q;
    assign res_wb.rob_entry  = rob_q;
    assign res_wb.phys_dest  = dest_q;
    assign res_wb.value      = result_q;

    assign flag_wb.valid     = valid_q;  // flags land with the result
    assign flag_wb.rob_entry = rob_q;
    assign flag_wb.phys_dest = flag_dest_q;
    assign flag_wb.value     = flags_q;

endmodule

// ==== phys_reg_file.sv ====
`timescale 1ns/1ps

module phys_reg_file import exec_pkg::*; #(
    parameter int num_read  = 8,
    parameter int num_write = 3
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  phys_reg_t            read_addrs [num_read],
    output word_t                read_vals  [num_read],
    input  logic [num_write-1:0] write_en,
    input  phys_reg_t            write_addrs [num_write],
    input  word_t                write_vals  [num_write]
);

    word_t regs [pr_count];

    // no bypass, a same-cycle read sees the old value
    always_comb begin
        for (int r = 0; r < num_read; r++) begin
            read_vals[r] = regs[read_addrs[r]];
        end
    end

    // later ports override earlier ones on the same register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < pr_count; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int w = 0; w < num_write; w++) begin
                if (write_en[w]) begin
                    regs[write_addrs[w]] <= write_vals[w];
                end
            end
        end
    end

endmodule

// ==== wb_if.sv ====
`timescale 1ns/1ps

// one write-back port into the register file
interface wb_if import exec_pkg::*; ();

    logic      valid;
    rob_idx_t  rob_entry;
    phys_reg_t phys_dest;
    word_t     value;

    modport source (
        output valid,
        output rob_entry,
        output phys_dest,
        output value
    );

    modport sink (
        input valid,
        input rob_entry,
        input phys_dest,
        input value
    );

endinterface

// ==== exec_pkg.sv ====
package exec_pkg;

    localparam int data_w    = 8;
    localparam int addr_w    = 16;
    localparam int pr_count  = 32;
    localparam int pr_addr_w = 5;
    localparam int ar_addr_w = 4;
    localparam int rob_w     = 5;
    localparam int imm_w     = 4;

    typedef logic [pr_addr_w-1:0] phys_reg_t;
    typedef logic [ar_addr_w-1:0] arch_reg_t;
    typedef logic [rob_w-1:0]     rob_idx_t;
    typedef logic [data_w-1:0]    word_t;
    typedef logic [addr_w-1:0]    addr_t;

    typedef enum logic [3:0] {
        op_add  = 4'h0,
        op_sub  = 4'h1,
        op_and  = 4'h2,
        op_or   = 4'h3,
        op_xor  = 4'h4,
        op_shl  = 4'h5,
        op_shr  = 4'h6,
        op_ldi  = 4'h7,  // zero-extended 4-bit immediate
        op_addi = 4'h8,
        op_ld   = 4'h9,
        op_st   = 4'ha,
        op_jmp  = 4'hb,
        op_jz   = 4'hc,
        op_jnz  = 4'hd,
        op_jc   = 4'he
    } op_e;

    // msb first, opcode on top
    typedef struct packed {
        op_e              opcode;
        rob_idx_t         rob_entry;
        phys_reg_t        src_a;
        phys_reg_t        src_b;
        phys_reg_t        src_c;
        phys_reg_t        phys_dest;
        phys_reg_t        phys_flag;
        arch_reg_t        arch_dest;
        logic [imm_w-1:0] imm;
    } renamed_op_t;

    // bit positions in the flags byte
    localparam int flag_z = 0;
    localparam int flag_c = 1;
    localparam int flag_n = 2;

endpackage
